// ==== camera.sv ====
`timescale 1ns/1ps

// Camera front end top level
// Register block, pan crop, debayer and metering chain

module camera
    import pixel_pkg::*, reg_pkg::*;
#(
    parameter int MAX_LINE_WIDTH = 64,
    parameter int METER_SHIFT = 6
) (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  video_t     pixel_i,            // From the byte-to-pixel converter
    input  op_code_t   op_code_i,
    input  logic       op_code_valid_i,
    input  logic [7:0] operand_i,
    input  logic       operand_valid_i,
    input  logic [2:0] operand_count_i,
    output logic [7:0] response_o,
    output logic       response_valid_o,
    output rgb_video_t rgb_o
);

    crop_window_t window;
    logic capture_start;
    video_t cropped;
    meter_t red_meter;
    meter_t green_meter;
    meter_t blue_meter;
    logic capture_done;

    spi_registers #(
        .MAX_LINE_WIDTH(MAX_LINE_WIDTH)
    ) spi_registers (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .op_code_i(op_code_i),
        .op_code_valid_i(op_code_valid_i),
        .operand_i(operand_i),
        .operand_valid_i(operand_valid_i),
        .operand_count_i(operand_count_i),
        .window_o(window),
        .capture_start_o(capture_start),
        .red_i(red_meter),
        .green_i(green_meter),
        .blue_i(blue_meter),
        .capture_done_i(capture_done),
        .response_o(response_o),
        .response_valid_o(response_valid_o)
    );

    crop pan_crop (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .video_i(pixel_i),
        .window_i(window),
        .video_o(cropped)
    );

    // Mosaic phase follows the low bits of the crop origin
    debayer #(
        .MAX_LINE_WIDTH(MAX_LINE_WIDTH)
    ) debayer (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .video_i(cropped),
        .x_phase_i(window.x_start[0]),
        .y_phase_i(window.y_start[0]),
        .video_o(rgb_o)
    );

    metering #(
        .METER_SHIFT(METER_SHIFT)
    ) metering (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .video_i(rgb_o),
        .capture_start_i(capture_start),
        .red_o(red_meter),
        .green_o(green_meter),
        .blue_o(blue_meter),
        .capture_done_o(capture_done)
    );

endmodule

// ==== camera_sva.sv ====
`timescale 1ns/1ps

// Bound protocol checks for the camera top level
// Input framing, response strobe width, RGB framing

module camera_sva
    import pixel_pkg::*;
(
    input logic       mipi_byte_clock,
    input logic       mipi_byte_reset_n,
    input video_t     pixel_i,
    input logic       response_valid_i,
    input rgb_video_t rgb_i
);

    int assertion_failures = 0;

    line_in_frame: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        $rose(pixel_i.line_valid) |-> pixel_i.frame_valid
    ) else begin
        assertion_failures = assertion_failures + 1;
        $error("Line valid rose outside a frame");
    end

    // Read answer is a single strobe
    response_single: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        response_valid_i |=> !response_valid_i
    ) else begin
        assertion_failures = assertion_failures + 1;
        $error("Response valid high for two cycles");
    end

    rgb_in_frame: assert property (
        @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        rgb_i.line_valid |-> rgb_i.frame_valid
    ) else begin
        assertion_failures = assertion_failures + 1;
        $error("RGB line valid outside a frame");
    end

endmodule

bind camera camera_sva protocol_checks (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .pixel_i(pixel_i),
    .response_valid_i(response_valid_o),
    .rgb_i(rgb_o)
);

// ==== camera_tb.sv ====
`timescale 1ns/1ps

// Camera front end testbench
// Random Bayer frames, register driver, reference model
// Per-test report, cycle timeout and closing summary

module camera_tb
    import pixel_pkg::*, reg_pkg::*;
();

    localparam int MAX_LINE_WIDTH = 64;
    localparam int METER_SHIFT = 6;
    localparam int NUM_FRAMES = 9;

    logic mipi_byte_clock = 1'b0;
    logic mipi_byte_reset_n;
    video_t pixel;
    op_code_t op_code;
    logic op_code_valid;
    logic [7:0] operand;
    logic operand_valid;
    logic [2:0] operand_count;
    logic [7:0] response;
    logic response_valid;
    rgb_video_t rgb;

    pixel_t image [MAX_LINE_WIDTH][MAX_LINE_WIDTH];
    int frame_width [NUM_FRAMES];
    int frame_height [NUM_FRAMES];
    logic [29:0] expected_q [$];    // {red, green, blue}
    logic [29:0] observed_q [$];
    int red_total;
    int green_total;
    int blue_total;
    int test_errors = 0;
    int passed_tests = 0;
    int failed_tests = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    camera #(
        .MAX_LINE_WIDTH(MAX_LINE_WIDTH),
        .METER_SHIFT(METER_SHIFT)
    ) UUT (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_i(pixel),
        .op_code_i(op_code),
        .op_code_valid_i(op_code_valid),
        .operand_i(operand),
        .operand_valid_i(operand_valid),
        .operand_count_i(operand_count),
        .response_o(response),
        .response_valid_o(response_valid),
        .rgb_o(rgb)
    );

    always #4 mipi_byte_clock = ~mipi_byte_clock;

    // RGB pixels collected mid-cycle
    always @(negedge mipi_byte_clock) begin
        if (mipi_byte_reset_n && rgb.line_valid) begin
            observed_q.push_back({rgb.red, rgb.green, rgb.blue});
        end
    end

    always @(posedge mipi_byte_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: no end of test after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge mipi_byte_clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s: expected %0h, actual %0h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic write_op(input op_code_t op);
        next_cycle();
        op_code = op;
        op_code_valid = 1'b1;
        next_cycle();
        op_code_valid = 1'b0;
    endtask

    task automatic write_operand(input int index, input logic [7:0] value);
        next_cycle();
        operand = value;
        operand_count = 3'(index);
        operand_valid = 1'b1;
        next_cycle();
        operand_valid = 1'b0;
    endtask

    task automatic set_window(input coord_t xs, input coord_t xe, input coord_t ys,
                              input coord_t ye);
        coord_t values [4];
        int i;
        values[0] = xs;
        values[1] = xe;
        values[2] = ys;
        values[3] = ye;
        write_op(OP_CROP_WINDOW);
        for (i = 0; i < 4; i++) begin
            write_operand(2 * i, {5'b0, values[i][10:8]});     // High byte first
            write_operand(2 * i + 1, values[i][7:0]);
        end
    endtask

    // Response must be a single strobe on the cycle after the op code
    task automatic read_reg(input string name, input op_code_t op, output logic [7:0] data);
        next_cycle();
        op_code = op;
        op_code_valid = 1'b1;
        @(negedge mipi_byte_clock);
        if (response_valid) begin
            $display("%s: response valid came in the op code cycle of %h", name, op);
            test_errors++;
        end
        next_cycle();
        op_code_valid = 1'b0;
        @(negedge mipi_byte_clock);
        if (!response_valid) begin
            $display("%s: no response valid after read op code %h", name, op);
            test_errors++;
        end
        data = response;
        @(negedge mipi_byte_clock);
        if (response_valid) begin
            $display("%s: response valid held a second cycle for %h", name, op);
            test_errors++;
        end
    endtask

    task automatic fill_image(input int index, input bit saturate);
        int x;
        int y;
        for (y = 0; y < frame_height[index]; y++) begin
            for (x = 0; x < frame_width[index]; x++) begin
                image[y][x] = saturate ? 10'h3ff : pixel_t'($urandom_range(1023, 0));
            end
        end
    endtask

    task automatic drive_frame(input int index);
        int x;
        int y;
        int gap;
        next_cycle();
        pixel.frame_valid = 1'b1;
        repeat (2) next_cycle();
        for (y = 0; y < frame_height[index]; y++) begin
            for (x = 0; x < frame_width[index]; x++) begin
                pixel.line_valid = 1'b1;
                pixel.data = image[y][x];
                next_cycle();
            end
            pixel.line_valid = 1'b0;
            pixel.data = '0;
            gap = $urandom_range(3, 1);     // Line blanking
            repeat (gap) next_cycle();
        end
        pixel.frame_valid = 1'b0;
    endtask

    // Crop, RGGB 2x2 demosaic and channel sums on the stored frame
    task automatic build_model(input int index, input int xs, input int xe, input int ys,
                               input int ye);
        int x_last;
        int y_last;
        int x;
        int y;
        int k;
        int px;
        int py;
        int greens;
        pixel_t red;
        pixel_t blue;
        x_last = (xe < frame_width[index]) ? xe : frame_width[index];
        y_last = (ye < frame_height[index]) ? ye : frame_height[index];
        expected_q.delete();
        red_total = 0;
        green_total = 0;
        blue_total = 0;
        // First cropped row and column have no complete window
        for (y = ys + 1; y < y_last; y++) begin
            for (x = xs + 1; x < x_last; x++) begin
                greens = 0;
                red = '0;
                blue = '0;
                for (k = 0; k < 4; k++) begin
                    py = y - 1 + k / 2;
                    px = x - 1 + k % 2;
                    if (py % 2 == 0 && px % 2 == 0) begin
                        red = image[py][px];        // R on even row, even column
                    end else if (py % 2 == 1 && px % 2 == 1) begin
                        blue = image[py][px];
                    end else begin
                        greens += image[py][px];
                    end
                end
                expected_q.push_back({red, pixel_t'(greens / 2), blue});
                red_total += red;
                green_total += greens / 2;
                blue_total += blue;
            end
        end
    endtask

    function automatic int scaled_meter(input int total);
        int shifted;
        shifted = total >> METER_SHIFT;
        return (shifted > 255) ? 255 : shifted;
    endfunction

    task automatic run_frame(input int index, input int xs, input int xe, input int ys,
                             input int ye, input bit saturate);
        fill_image(index, saturate);
        build_model(index, xs, xe, ys, ye);
        observed_q.delete();
        drive_frame(index);
        repeat (6) next_cycle();    // Crop, debayer and metering latency
    endtask

    task automatic compare_stream(input string name);
        int i;
        if (observed_q.size() != expected_q.size()) begin
            $display("Error %s: expected %0d pixels, actual %0d", name,
                     expected_q.size(), observed_q.size());
            test_errors++;
        end else begin
            for (i = 0; i < expected_q.size(); i++) begin
                check_value(name, expected_q[i], observed_q[i]);
            end
        end
    endtask

    task automatic check_meters(input string name, input int red, input int green,
                                input int blue);
        logic [7:0] data;
        read_reg(name, OP_METER_RED, data);
        check_value(name, red, data);
        read_reg(name, OP_METER_GREEN, data);
        check_value(name, green, data);
        read_reg(name, OP_METER_BLUE, data);
        check_value(name, blue, data);
    endtask

    task automatic check_status(input string name, input logic done);
        logic [7:0] data;
        read_reg(name, OP_STATUS, data);
        check_value(name, {7'b0, done}, data);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("PASS %s", name);
            passed_tests++;
        end else begin
            $display("FAIL %s with %0d errors", name, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    initial begin
        int i;
        int total;
        int xs;
        int xe;
        int ys;
        int ye;
        int red_expect;
        int green_expect;
        int blue_expect;
        mipi_byte_reset_n = 1'b0;
        pixel = '0;
        op_code = '0;
        op_code_valid = 1'b0;
        operand = '0;
        operand_valid = 1'b0;
        operand_count = '0;
        void'($urandom(32'hc545));

        total = 0;
        for (i = 0; i < NUM_FRAMES; i++) begin
            frame_width[i] = $urandom_range(24, 8);
            frame_height[i] = $urandom_range(16, 6);
            total += 12 + frame_height[i] * (frame_width[i] + 4);
        end
        cycle_limit = 2 * total + 1000;

        repeat (2) @(posedge mipi_byte_clock);
        #1 mipi_byte_reset_n = 1'b1;

        // Reset window covers the whole image
        run_frame(0, 0, MAX_LINE_WIDTH, 0, MAX_LINE_WIDTH, 1'b0);
        compare_stream("full_window");
        finish_test("full_window");

        for (i = 0; i < 3; i++) begin
            xs = $urandom_range(3, 0);
            ys = $urandom_range(3, 0);
            if (i == 0) begin
                xs = xs | 1;        // Odd origin shifts the mosaic phase
                ys = ys | 1;
            end
            xe = xs + $urandom_range(frame_width[1 + i] - xs, 3);
            ye = ys + $urandom_range(frame_height[1 + i] - ys, 3);
            set_window(coord_t'(xs), coord_t'(xe), coord_t'(ys), coord_t'(ye));
            run_frame(1 + i, xs, xe, ys, ye, 1'b0);
            compare_stream("random_crop");
        end
        finish_test("random_crop");

        // Sixteen RGB pixels keep the averages below saturation
        set_window(0, 5, 0, 5);
        write_op(OP_START_CAPTURE);
        check_status("meter_capture", 1'b0);
        run_frame(4, 0, 5, 0, 5, 1'b0);
        check_status("meter_capture", 1'b1);
        check_meters("meter_capture", scaled_meter(red_total), scaled_meter(green_total),
                     scaled_meter(blue_total));
        finish_test("meter_capture");

        set_window(0, coord_t'(MAX_LINE_WIDTH), 0, coord_t'(MAX_LINE_WIDTH));
        write_op(OP_START_CAPTURE);
        run_frame(5, 0, MAX_LINE_WIDTH, 0, MAX_LINE_WIDTH, 1'b1);
        check_status("meter_saturation", 1'b1);
        check_meters("meter_saturation", 255, 255, 255);
        finish_test("meter_saturation");

        set_window(0, 5, 0, 5);
        write_op(OP_START_CAPTURE);
        run_frame(6, 0, 5, 0, 5, 1'b0);
        check_status("rearm", 1'b1);
        write_op(OP_START_CAPTURE);
        check_status("rearm", 1'b0);
        run_frame(7, 0, 5, 0, 5, 1'b0);
        check_status("rearm", 1'b1);
        red_expect = scaled_meter(red_total);
        green_expect = scaled_meter(green_total);
        blue_expect = scaled_meter(blue_total);
        check_meters("rearm", red_expect, green_expect, blue_expect);
        // A frame without a new capture leaves the results in place
        run_frame(8, 0, 5, 0, 5, 1'b0);
        check_status("rearm", 1'b1);
        check_meters("rearm", red_expect, green_expect, blue_expect);
        finish_test("rearm");

        // Every read checks its strobe and an unknown op code gives none
        check_status("register_reads", 1'b1);
        check_meters("register_reads", red_expect, green_expect, blue_expect);
        write_op(8'h00);
        repeat (2) begin
            @(negedge mipi_byte_clock);
            if (response_valid) begin
                $display("register_reads: response valid after an unknown op code");
                test_errors++;
            end
        end
        finish_test("register_reads");

        $display("Summary: %0d run, %0d passed, %0d failed", passed_tests + failed_tests,
                 passed_tests, failed_tests);
        if (failed_tests == 0 && UUT.protocol_checks.assertion_failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== crop.sv ====
`timescale 1ns/1ps

// Pan crop on the Bayer stream
// Counts pixel and line position, gates line valid by the window

module crop
    import pixel_pkg::*, reg_pkg::*;
(
    input  logic         mipi_byte_clock,
    input  logic         mipi_byte_reset_n,
    input  video_t       video_i,
    input  crop_window_t window_i,
    output video_t       video_o
);

    coord_t x_count;    // Position of the current pixel in its line
    coord_t y_count;    // Line number within the frame
    logic line_valid_q;
    logic in_window;

    logic frame_valid_q;
    logic window_valid_q;
    pixel_t data_q;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= video_i.line_valid;

            if (video_i.line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
            end

            // Idle between frames, so every frame starts on row 0
            if (!video_i.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_q && !video_i.line_valid) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    always_comb begin
        in_window = video_i.line_valid &&
                    (x_count >= window_i.x_start) && (x_count < window_i.x_end) &&
                    (y_count >= window_i.y_start) && (y_count < window_i.y_end);
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            window_valid_q <= 1'b0;
        end else begin
            frame_valid_q <= video_i.frame_valid;
            window_valid_q <= in_window;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_q <= video_i.data;
    end

    always_comb begin
        video_o.frame_valid = frame_valid_q;
        video_o.line_valid = window_valid_q;
        video_o.data = data_q;
    end

endmodule

// ==== debayer.sv ====
`timescale 1ns/1ps

// 2x2 RGGB demosaic
// One-line buffer for the previous row, previous pixel of both rows
// Phase of the mosaic set by the low bits of the crop start

module debayer
    import pixel_pkg::*;
#(
    parameter int MAX_LINE_WIDTH = 64
) (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  video_t     video_i,
    input  logic       x_phase_i,
    input  logic       y_phase_i,
    output rgb_video_t video_o
);

    localparam int ADDR_WIDTH = $clog2(MAX_LINE_WIDTH);

    pixel_t line_buffer [MAX_LINE_WIDTH];   // Previous cropped row
    logic [ADDR_WIDTH-1:0] address;

    coord_t x_count;
    coord_t y_count;
    logic line_valid_q;

    // 2x2 window, bottom right is the incoming pixel
    pixel_t top_left;
    pixel_t top_right;
    pixel_t bottom_left;
    pixel_t bottom_right;

    bayer_site_t site;
    logic [10:0] green_sum;
    logic window_valid;
    pixel_t red;
    pixel_t blue;

    logic frame_valid_q;
    logic rgb_valid_q;
    pixel_t red_q;
    pixel_t green_q;
    pixel_t blue_q;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= video_i.line_valid;

            if (video_i.line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
            end

            if (!video_i.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_q && !video_i.line_valid) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    always_comb begin
        address = x_count[ADDR_WIDTH-1:0];
        top_right = line_buffer[address];
        bottom_right = video_i.data;
        window_valid = video_i.line_valid && (x_count != '0) && (y_count != '0);
        site = {y_count[0] ^ y_phase_i, x_count[0] ^ x_phase_i};   // Site of bottom right
    end

    // Route the four window pixels by where red falls
    always_comb begin
        case (site)
            SITE_RED: begin
                red = bottom_right;
                blue = top_left;
                green_sum = top_right + bottom_left;
            end
            SITE_GREEN_R: begin
                red = bottom_left;
                blue = top_right;
                green_sum = top_left + bottom_right;
            end
            SITE_GREEN_B: begin
                red = top_right;
                blue = bottom_left;
                green_sum = top_left + bottom_right;
            end
            default: begin      // SITE_BLUE
                red = top_left;
                blue = bottom_right;
                green_sum = top_right + bottom_left;
            end
        endcase
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            rgb_valid_q <= 1'b0;
        end else begin
            frame_valid_q <= video_i.frame_valid;
            rgb_valid_q <= window_valid;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (video_i.line_valid) begin
            line_buffer[address] <= video_i.data;
            top_left <= top_right;
            bottom_left <= video_i.data;
        end
        red_q <= red;
        green_q <= green_sum[10:1];    // Average of the two greens
        blue_q <= blue;
    end

    always_comb begin
        video_o.frame_valid = frame_valid_q;
        video_o.line_valid = rgb_valid_q;
        video_o.red = red_q;
        video_o.green = green_q;
        video_o.blue = blue_q;
    end

endmodule

// ==== list.f ====
pixel_pkg.sv
reg_pkg.sv
crop.sv
debayer.sv
metering.sv
spi_registers.sv
camera.sv
camera_sva.sv
camera_tb.sv

// ==== metering.sv ====
`timescale 1ns/1ps

// Per-channel frame metering
// Capture FSM, channel sums, scaled and saturated 8-bit results

module metering
    import pixel_pkg::*;
#(
    parameter int METER_SHIFT = 6
) (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  rgb_video_t video_i,
    input  logic       capture_start_i,
    output meter_t     red_o,
    output meter_t     green_o,
    output meter_t     blue_o,
    output logic       capture_done_o
);

    typedef enum logic [1:0] {IDLE, ARMED, MEASURING, DONE} state_t;
    typedef logic [31:0] sum_t;

    state_t state;
    logic frame_valid_q;
    logic frame_start;
    logic frame_end;
    sum_t red_sum;
    sum_t green_sum;
    sum_t blue_sum;

    function automatic meter_t scale(input sum_t sum);
        sum_t shifted;
        shifted = sum >> METER_SHIFT;
        if (shifted > sum_t'(255)) begin
            scale = 8'hff;      // Saturate
        end else begin
            scale = shifted[7:0];
        end
    endfunction

    always_comb begin
        frame_start = video_i.frame_valid && !frame_valid_q;
        frame_end = !video_i.frame_valid && frame_valid_q;
        capture_done_o = (state == DONE);
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state <= IDLE;
            frame_valid_q <= 1'b0;
            red_o <= '0;
            green_o <= '0;
            blue_o <= '0;
        end else begin
            frame_valid_q <= video_i.frame_valid;
            if (capture_start_i) begin
                state <= ARMED;     // Re-arm from any state
            end else begin
                case (state)
                    ARMED: begin
                        if (frame_start) state <= MEASURING;
                    end
                    MEASURING: begin
                        if (frame_end) begin
                            state <= DONE;
                            red_o <= scale(red_sum);
                            green_o <= scale(green_sum);
                            blue_o <= scale(blue_sum);
                        end
                    end
                    default: state <= state;
                endcase
            end
        end
    end

    // Sums restart with every frame
    always_ff @(posedge mipi_byte_clock) begin
        if (frame_start) begin
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
        end else if (video_i.line_valid) begin
            red_sum <= red_sum + sum_t'(video_i.red);
            green_sum <= green_sum + sum_t'(video_i.green);
            blue_sum <= blue_sum + sum_t'(video_i.blue);
        end
    end

endmodule

// ==== pixel_pkg.sv ====
// Pixel stream types for the camera pipeline
// Sample, coordinate and metering widths
// Bayer and RGB video structs, RGGB site codes

package pixel_pkg;

    typedef logic [9:0] pixel_t;    // Raw or colour sample
    typedef logic [7:0] meter_t;    // Scaled channel average
    typedef logic [10:0] coord_t;   // Pixel coordinate or count

    // Bayer stream as delivered by the byte-to-pixel converter
    typedef struct packed {
        logic frame_valid;
        logic line_valid;
        pixel_t data;
    } video_t;

    // Debayered stream, one colour triple per pixel
    typedef struct packed {
        logic frame_valid;
        logic line_valid;
        pixel_t red;
        pixel_t green;
        pixel_t blue;
    } rgb_video_t;

    // Mosaic site of a pixel, indexed by {y parity, x parity}
    typedef logic [1:0] bayer_site_t;

    localparam bayer_site_t SITE_RED = 2'b00;
    localparam bayer_site_t SITE_GREEN_R = 2'b01;   // Green on a red row
    localparam bayer_site_t SITE_GREEN_B = 2'b10;   // Green on a blue row
    localparam bayer_site_t SITE_BLUE = 2'b11;

endpackage

// ==== reg_pkg.sv ====
// Register port definitions
// Op codes, crop window struct and status byte layout

package reg_pkg;

    import pixel_pkg::*;

    typedef logic [7:0] op_code_t;

    // Write op codes
    localparam op_code_t OP_CROP_WINDOW = 8'h20;     // Eight operands, high byte first
    localparam op_code_t OP_START_CAPTURE = 8'h21;

    // Read op codes
    localparam op_code_t OP_STATUS = 8'h22;
    localparam op_code_t OP_METER_RED = 8'h30;
    localparam op_code_t OP_METER_GREEN = 8'h31;
    localparam op_code_t OP_METER_BLUE = 8'h32;

    // Start is inclusive, end is exclusive
    typedef struct packed {
        coord_t x_start;
        coord_t x_end;
        coord_t y_start;
        coord_t y_end;
    } crop_window_t;

    localparam logic [2:0] CROP_LAST_OPERAND = 3'd7;   // Commits the window

    localparam int STATUS_CAPTURE_DONE = 0;            // Bit in the status byte

endpackage

// ==== run.sh ====
#!/bin/sh
# Builds the camera testbench with Verilator and runs it
# Exit status follows the pass line in the simulation output

cd "$(dirname "$0")" && verilator --binary --assert -Wno-fatal --top-module camera_tb \
    -f list.f -o camera_sim || exit 1
output=$(./obj_dir/camera_sim)
echo "$output"
echo "$output" | grep -qx "all tests passed" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== spi_registers.sv ====
`timescale 1ns/1ps

// Register port decoder
// Crop window shadow and commit, capture start pulse, read responses

module spi_registers
    import pixel_pkg::*, reg_pkg::*;
#(
    parameter int MAX_LINE_WIDTH = 64
) (
    input  logic         mipi_byte_clock,
    input  logic         mipi_byte_reset_n,
    input  op_code_t     op_code_i,
    input  logic         op_code_valid_i,
    input  logic [7:0]   operand_i,
    input  logic         operand_valid_i,
    input  logic [2:0]   operand_count_i,
    output crop_window_t window_o,
    output logic         capture_start_o,
    input  meter_t       red_i,
    input  meter_t       green_i,
    input  meter_t       blue_i,
    input  logic         capture_done_i,
    output logic [7:0]   response_o,
    output logic         response_valid_o
);

    // Full square image until a window is written
    localparam crop_window_t RESET_WINDOW = '{
        x_start: '0,
        x_end: coord_t'(MAX_LINE_WIDTH),
        y_start: '0,
        y_end: coord_t'(MAX_LINE_WIDTH)
    };

    op_code_t op_code_q;
    crop_window_t shadow;
    crop_window_t shadow_next;
    logic crop_write;
    logic [7:0] status;
    logic [7:0] read_data;
    logic read_valid;

    always_comb begin
        crop_write = operand_valid_i && (op_code_q == OP_CROP_WINDOW);
        shadow_next = shadow;
        case (operand_count_i)      // High byte then low byte per coordinate
            3'd0: shadow_next.x_start[10:8] = operand_i[2:0];
            3'd1: shadow_next.x_start[7:0] = operand_i;
            3'd2: shadow_next.x_end[10:8] = operand_i[2:0];
            3'd3: shadow_next.x_end[7:0] = operand_i;
            3'd4: shadow_next.y_start[10:8] = operand_i[2:0];
            3'd5: shadow_next.y_start[7:0] = operand_i;
            3'd6: shadow_next.y_end[10:8] = operand_i[2:0];
            default: shadow_next.y_end[7:0] = operand_i;
        endcase
    end

    always_comb begin
        status = '0;
        status[STATUS_CAPTURE_DONE] = capture_done_i;
        read_valid = 1'b1;
        case (op_code_i)
            OP_STATUS: read_data = status;
            OP_METER_RED: read_data = red_i;
            OP_METER_GREEN: read_data = green_i;
            OP_METER_BLUE: read_data = blue_i;
            default: begin
                read_data = '0;
                read_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            op_code_q <= '0;
            shadow <= RESET_WINDOW;
            window_o <= RESET_WINDOW;
            capture_start_o <= 1'b0;
            response_valid_o <= 1'b0;
        end else begin
            if (op_code_valid_i) op_code_q <= op_code_i;
            if (crop_write) begin
                shadow <= shadow_next;
                if (operand_count_i == CROP_LAST_OPERAND) window_o <= shadow_next;
            end
            capture_start_o <= op_code_valid_i && (op_code_i == OP_START_CAPTURE);
            response_valid_o <= op_code_valid_i && read_valid;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (op_code_valid_i) response_o <= read_data;
    end

endmodule
